// ==== include/issue_params.svh ====
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ------------------------------
// datapath widths
// ------------------------------

// integer data width
`define ISSUE_XLEN 64

// architectural register address width
`define ISSUE_REG_ADDR_W 5

// number of commit write ports into the register file
`define ISSUE_NR_COMMIT 2

// scoreboard transaction id width
`define ISSUE_TRANS_ID_W 3

// virtual pc width, sign-extended when used as an operand
`define ISSUE_VLEN 39

`endif

// ==== logic/gpr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module gpr_regfile (
  input  logic                                        clk_i,
  input  logic                                        rst_uarch_ni,
  input  logic [`ISSUE_REG_ADDR_W-1:0]                raddr_a_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0]                raddr_b_i,
  input  issue_pkg::commit_wr_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  output logic [`ISSUE_XLEN-1:0]                      rdata_a_o,
  output logic [`ISSUE_XLEN-1:0]                      rdata_b_o
);

  localparam int unsigned NR_REGS = 2**`ISSUE_REG_ADDR_W;

  // x1..x31 only, x0 has no storage
  logic [`ISSUE_XLEN-1:0] regs_q    [1:NR_REGS-1];
  // read view with x0 tied to zero
  logic [`ISSUE_XLEN-1:0] read_view [0:NR_REGS-1];

  // ------------------------------
  // write ports
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int unsigned r = 1; r < NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned r = 1; r < NR_REGS; r++) begin
        // later ports override earlier ones on the same address
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
          if (commit_i[p].we && commit_i[p].waddr == r[`ISSUE_REG_ADDR_W-1:0]) begin
            regs_q[r] <= commit_i[p].wdata;
          end
        end
      end
    end
  end

  // ------------------------------
  // read ports
  // ------------------------------
  always_comb begin
    read_view[0] = '0;
    for (int unsigned r = 1; r < NR_REGS; r++) begin
      read_view[r] = regs_q[r];
    end
  end

  // same cycle writes are not bypassed here
  assign rdata_a_o = read_view[raddr_a_i];
  assign rdata_b_o = read_view[raddr_b_i];

endmodule

`default_nettype wire

// ==== logic/issue_ex_register.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module issue_ex_register (
  input  logic                     clk_i,
  input  logic                     rst_uarch_ni,
  input  logic                     flush_i,
  input  logic                     accept_i,
  input  issue_pkg::issue_entry_t  issue_entry_i,
  input  logic [`ISSUE_XLEN-1:0]   operand_a_i,
  input  logic [`ISSUE_XLEN-1:0]   operand_b_i,
  input  logic [`ISSUE_XLEN-1:0]   imm_i,
  output issue_pkg::fu_data_t      fu_data_o,
  output issue_pkg::fu_valid_t     fu_valid_o,
  output logic                     mult_issued_o
);

  issue_pkg::fu_data_t  fu_data_d;
  issue_pkg::fu_data_t  fu_data_q;
  issue_pkg::fu_valid_t fu_valid_d;
  issue_pkg::fu_valid_t fu_valid_q;

  // ------------------------------
  // execute data
  // ------------------------------
  always_comb begin
    fu_data_d.fu        = issue_entry_i.fu;
    fu_data_d.operation = issue_entry_i.op;
    fu_data_d.operand_a = operand_a_i;
    fu_data_d.operand_b = operand_b_i;
    fu_data_d.imm       = imm_i;
    fu_data_d.trans_id  = issue_entry_i.trans_id;
  end

  // ------------------------------
  // unit decode
  // ------------------------------
  always_comb begin
    fu_valid_d = '0;
    if (accept_i) begin
      case (issue_entry_i.fu)
        issue_pkg::ALU:       fu_valid_d.alu    = 1'b1;
        issue_pkg::CTRL_FLOW: fu_valid_d.branch = 1'b1;
        issue_pkg::LOAD,
        issue_pkg::STORE:     fu_valid_d.lsu    = 1'b1;
        issue_pkg::MULT:      fu_valid_d.mult   = 1'b1;
        issue_pkg::CSR:       fu_valid_d.csr    = 1'b1;
        // NONE starts nothing
        default:              fu_valid_d        = '0;
      endcase
    end
    // a flush must not start any unit with stale operands
    if (flush_i) begin
      fu_valid_d = '0;
    end
  end

  // ------------------------------
  // id/ex stage flops
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      fu_data_q.fu        <= issue_pkg::NONE;
      fu_data_q.operation <= issue_pkg::ADD;
      fu_data_q.operand_a <= '0;
      fu_data_q.operand_b <= '0;
      fu_data_q.imm       <= '0;
      fu_data_q.trans_id  <= '0;
      fu_valid_q          <= '0;
    end else begin
      // data moves every cycle, the valids qualify it
      fu_data_q  <= fu_data_d;
      fu_valid_q <= fu_valid_d;
    end
  end

  assign fu_data_o  = fu_data_q;
  assign fu_valid_o = fu_valid_q;

  // fed back to block fixed latency issue next cycle
  assign mult_issued_o = fu_valid_q.mult;

endmodule

`default_nettype wire

// ==== logic/issue_pkg.sv ====
`default_nettype none

`include "issue_params.svh"

package issue_pkg;

  // ------------------------------
  // unit and operation encodings
  // ------------------------------

  // functional unit an entry needs
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    ALU       = 4'd1,
    CTRL_FLOW = 4'd2,
    LOAD      = 4'd3,
    STORE     = 4'd4,
    MULT      = 4'd5,
    CSR       = 4'd6
  } fu_t;

  // small subset of the operations, ADD must stay at zero
  typedef enum logic [6:0] {
    ADD    = 7'd0,
    SUB    = 7'd1,
    AND_OP = 7'd2,
    OR_OP  = 7'd3,
    XOR_OP = 7'd4,
    SLL    = 7'd5,
    BEQ    = 7'd6,
    JAL    = 7'd7,
    LD     = 7'd8,
    SD     = 7'd9,
    MUL    = 7'd10,
    CSRRW  = 7'd11
  } fu_op_t;

  // ------------------------------
  // bundles
  // ------------------------------

  // one scoreboard entry offered for issue
  typedef struct packed {
    logic [`ISSUE_VLEN-1:0]       pc;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
    fu_t                          fu;
    fu_op_t                       op;
    logic [`ISSUE_REG_ADDR_W-1:0] rs1;
    logic [`ISSUE_REG_ADDR_W-1:0] rs2;
    logic [`ISSUE_REG_ADDR_W-1:0] rd;
    // immediate value carried in the result field
    logic [`ISSUE_XLEN-1:0]       result;
    logic                         use_imm;
    logic                         use_zimm;
    logic                         use_pc;
    // entry already carries an exception
    logic                         ex_valid;
  } issue_entry_t;

  // one commit write port
  typedef struct packed {
    logic                         we;
    logic [`ISSUE_REG_ADDR_W-1:0] waddr;
    logic [`ISSUE_XLEN-1:0]       wdata;
  } commit_wr_t;

  // operands and control handed to execute
  typedef struct packed {
    fu_t                          fu;
    fu_op_t                       operation;
    logic [`ISSUE_XLEN-1:0]       operand_a;
    logic [`ISSUE_XLEN-1:0]       operand_b;
    logic [`ISSUE_XLEN-1:0]       imm;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  // one start pulse per unit
  typedef struct packed {
    logic alu;
    logic branch;
    logic lsu;
    logic mult;
    logic csr;
  } fu_valid_t;

  // pending writer of each register, NONE when free
  typedef fu_t [2**`ISSUE_REG_ADDR_W-1:0] clobber_t;

endpackage

`default_nettype wire

// ==== logic/issue_read_operands.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module issue_read_operands (
  input  logic                                        clk_i,
  input  logic                                        rst_uarch_ni,
  input  logic                                        flush_i,
  input  logic                                        stall_i,
  input  issue_pkg::issue_entry_t                     issue_entry_i,
  input  logic                                        issue_valid_i,
  output logic                                        issue_ack_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]                rs1_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]                rs2_o,
  input  logic [`ISSUE_XLEN-1:0]                      rs1_i,
  input  logic [`ISSUE_XLEN-1:0]                      rs2_i,
  input  logic                                        rs1_valid_i,
  input  logic                                        rs2_valid_i,
  input  issue_pkg::clobber_t                         clobber_i,
  input  issue_pkg::commit_wr_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  input  logic                                        flu_ready_i,
  input  logic                                        lsu_ready_i,
  output issue_pkg::fu_data_t                         fu_data_o,
  output issue_pkg::fu_valid_t                        fu_valid_o,
  output logic                                        stall_issue_o
);

  logic                   forward_rs1;
  logic                   forward_rs2;
  logic                   accept;
  logic                   mult_issued;
  logic [`ISSUE_XLEN-1:0] rdata_a;
  logic [`ISSUE_XLEN-1:0] rdata_b;
  logic [`ISSUE_XLEN-1:0] operand_a;
  logic [`ISSUE_XLEN-1:0] operand_b;
  logic [`ISSUE_XLEN-1:0] imm;

  // scoreboard lookup uses the source fields directly
  assign rs1_o = issue_entry_i.rs1;
  assign rs2_o = issue_entry_i.rs2;

  // ------------------------------
  // hazard check and handshake
  // ------------------------------
  operand_hazard_check operand_hazard_check_inst (
    .issue_entry_i (issue_entry_i),
    .issue_valid_i (issue_valid_i),
    .clobber_i     (clobber_i),
    .rs1_valid_i   (rs1_valid_i),
    .rs2_valid_i   (rs2_valid_i),
    .commit_i      (commit_i),
    .flu_ready_i   (flu_ready_i),
    .lsu_ready_i   (lsu_ready_i),
    .stall_i       (stall_i),
    .mult_issued_i (mult_issued),
    .forward_rs1_o (forward_rs1),
    .forward_rs2_o (forward_rs2),
    .issue_ack_o   (issue_ack_o),
    .accept_o      (accept),
    .stall_issue_o (stall_issue_o)
  );

  // ------------------------------
  // register read and operand mux
  // ------------------------------
  gpr_regfile gpr_regfile_inst (
    .clk_i        (clk_i),
    .rst_uarch_ni (rst_uarch_ni),
    .raddr_a_i    (issue_entry_i.rs1),
    .raddr_b_i    (issue_entry_i.rs2),
    .commit_i     (commit_i),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b)
  );

  operand_select operand_select_inst (
    .issue_entry_i (issue_entry_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .forward_rs1_i (forward_rs1),
    .forward_rs2_i (forward_rs2),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .imm_o         (imm)
  );

  // ------------------------------
  // id/ex register
  // ------------------------------
  issue_ex_register issue_ex_register_inst (
    .clk_i         (clk_i),
    .rst_uarch_ni  (rst_uarch_ni),
    .flush_i       (flush_i),
    .accept_i      (accept),
    .issue_entry_i (issue_entry_i),
    .operand_a_i   (operand_a),
    .operand_b_i   (operand_b),
    .imm_i         (imm),
    .fu_data_o     (fu_data_o),
    .fu_valid_o    (fu_valid_o),
    .mult_issued_o (mult_issued)
  );

endmodule

`default_nettype wire

// ==== logic/operand_hazard_check.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module operand_hazard_check (
  input  issue_pkg::issue_entry_t                     issue_entry_i,
  input  logic                                        issue_valid_i,
  input  issue_pkg::clobber_t                         clobber_i,
  input  logic                                        rs1_valid_i,
  input  logic                                        rs2_valid_i,
  input  issue_pkg::commit_wr_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  input  logic                                        flu_ready_i,
  input  logic                                        lsu_ready_i,
  input  logic                                        stall_i,
  input  logic                                        mult_issued_i,
  output logic                                        forward_rs1_o,
  output logic                                        forward_rs2_o,
  output logic                                        issue_ack_o,
  output logic                                        accept_o,
  output logic                                        stall_issue_o
);

  logic fu_busy;
  logic operand_stall;
  logic rd_free;

  // ------------------------------
  // unit busy
  // ------------------------------
  always_comb begin
    unique case (issue_entry_i.fu)
      issue_pkg::ALU, issue_pkg::CTRL_FLOW,
      issue_pkg::CSR, issue_pkg::MULT:  fu_busy = ~flu_ready_i;
      issue_pkg::LOAD, issue_pkg::STORE: fu_busy = ~lsu_ready_i;
      // NONE needs no unit
      default:                           fu_busy = 1'b0;
    endcase
  end

  // ------------------------------
  // operand availability
  // ------------------------------
  always_comb begin
    operand_stall = stall_i;
    forward_rs1_o = 1'b0;
    forward_rs2_o = 1'b0;
    // zimm takes rs1 as a constant, nothing to wait on
    if (!issue_entry_i.use_zimm && clobber_i[issue_entry_i.rs1] != issue_pkg::NONE) begin
      // csr results only come back through the register file
      if (rs1_valid_i && clobber_i[issue_entry_i.rs1] != issue_pkg::CSR) begin
        forward_rs1_o = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
    if (clobber_i[issue_entry_i.rs2] != issue_pkg::NONE) begin
      if (rs2_valid_i && clobber_i[issue_entry_i.rs2] != issue_pkg::CSR) begin
        forward_rs2_o = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
  end

  assign stall_issue_o = operand_stall;

  // ------------------------------
  // write after write on rd
  // ------------------------------
  always_comb begin
    rd_free = (clobber_i[issue_entry_i.rd] == issue_pkg::NONE);
    // the pending writer retires this cycle, so rd frees up
    for (int unsigned i = 0; i < `ISSUE_NR_COMMIT; i++) begin
      if (commit_i[i].we && commit_i[i].waddr == issue_entry_i.rd) begin
        rd_free = 1'b1;
      end
    end
  end

  // ------------------------------
  // issue acknowledge
  // ------------------------------
  always_comb begin
    issue_ack_o = issue_valid_i && !operand_stall && !fu_busy && rd_free;
    // exceptions and unit-less entries go through regardless
    if (issue_valid_i && (issue_entry_i.ex_valid || issue_entry_i.fu == issue_pkg::NONE)) begin
      issue_ack_o = 1'b1;
    end
    // the multiplier owns the fixed latency writeback next cycle
    if (mult_issued_i && issue_entry_i.fu inside {issue_pkg::ALU, issue_pkg::CTRL_FLOW,
                                                  issue_pkg::CSR}) begin
      issue_ack_o = 1'b0;
    end
  end

  // only clean entries start a unit
  assign accept_o = issue_ack_o && issue_valid_i && !issue_entry_i.ex_valid;

endmodule

`default_nettype wire

// ==== logic/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module operand_select (
  input  issue_pkg::issue_entry_t  issue_entry_i,
  input  logic [`ISSUE_XLEN-1:0]   rdata_a_i,
  input  logic [`ISSUE_XLEN-1:0]   rdata_b_i,
  input  logic [`ISSUE_XLEN-1:0]   rs1_i,
  input  logic [`ISSUE_XLEN-1:0]   rs2_i,
  input  logic                     forward_rs1_i,
  input  logic                     forward_rs2_i,
  output logic [`ISSUE_XLEN-1:0]   operand_a_o,
  output logic [`ISSUE_XLEN-1:0]   operand_b_o,
  output logic [`ISSUE_XLEN-1:0]   imm_o
);

  logic [`ISSUE_XLEN-1:0] pc_sext;
  logic [`ISSUE_XLEN-1:0] zimm_zext;
  logic                   imm_on_b;

  // ------------------------------
  // operand a sources
  // ------------------------------

  // pc widened with its top bit
  assign pc_sext = {{(`ISSUE_XLEN - `ISSUE_VLEN){issue_entry_i.pc[`ISSUE_VLEN-1]}},
                    issue_entry_i.pc};

  // csr immediate sits in the rs1 field
  assign zimm_zext = {{(`ISSUE_XLEN - `ISSUE_REG_ADDR_W){1'b0}}, issue_entry_i.rs1};

  always_comb begin
    // register file first, then forward, pc and zimm in rising priority
    operand_a_o = rdata_a_i;
    if (forward_rs1_i) begin
      operand_a_o = rs1_i;
    end
    if (issue_entry_i.use_pc) begin
      operand_a_o = pc_sext;
    end
    if (issue_entry_i.use_zimm) begin
      operand_a_o = zimm_zext;
    end
  end

  // ------------------------------
  // operand b sources
  // ------------------------------

  // stores and branches keep rs2 on b, their immediate goes via imm
  assign imm_on_b = issue_entry_i.use_imm &&
                    issue_entry_i.fu != issue_pkg::STORE &&
                    issue_entry_i.fu != issue_pkg::CTRL_FLOW;

  always_comb begin
    operand_b_o = rdata_b_i;
    if (forward_rs2_i) begin
      operand_b_o = rs2_i;
    end
    if (imm_on_b) begin
      operand_b_o = issue_entry_i.result;
    end
  end

  // immediate always travels on its own lane too
  assign imm_o = issue_entry_i.result;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module tb_issue_read_operands -o tb_issue_read_operands

# the verdict comes from the pass line in the simulation output
out=$(./obj_dir/tb_issue_read_operands 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED"

// ==== sources.f ====
+incdir+include
logic/issue_pkg.sv
logic/operand_hazard_check.sv
logic/gpr_regfile.sv
logic/operand_select.sv
logic/issue_ex_register.sv
logic/issue_read_operands.sv
test/tb_issue_read_operands.sv

// ==== test/issue_testdata.txt ====
# hex: valid fu op rs1 rs2 rd pc imm flags[imm,zimm,pc,ex] we0 wa0 wd0 we1 wa1 wd1
# clob_rs1 clob_rs2 clob_rd sb1 sb1_ok sb2 sb2_ok ctl[flu,lsu,stall,flush] ack stl a b valid
0 0 0 00 00 00 0 0 0 1 05 1111 1 06 2222 0 0 0 0 0 0 0 c 0 0 0 0 00
1 1 0 05 06 07 0 0 0 1 00 dead 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 2222 10
1 1 0 00 05 08 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 0 1111 10
1 1 0 05 06 09 0 0 0 0 00 0 0 00 0 1 0 0 abcd 1 0 0 c 1 0 abcd 2222 10
1 1 0 05 06 09 0 0 0 0 00 0 0 00 0 1 0 0 abcd 0 0 0 c 0 1 0 0 00
1 1 0 05 06 09 0 0 0 0 00 0 0 00 0 0 6 0 0 0 5555 1 c 0 1 0 0 00
1 1 0 00 00 0a 4000000000 10 a 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 ffffffc000000000 10 10
1 6 b 1f 00 0b 0 0 4 0 00 0 0 00 0 1 0 0 0 0 0 0 c 1 0 1f 0 01
1 4 9 05 06 00 0 8 8 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 2222 04
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 4 0 0 0 0 00
1 3 8 05 00 0d 0 10 8 0 00 0 0 00 0 0 0 0 0 0 0 0 8 0 0 0 0 00
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 8 1 0 1111 2222 10
1 3 8 05 00 0d 0 10 8 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 10 04
1 2 6 05 06 00 0 20 8 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 2222 08
1 5 a 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 2222 02
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 c 0 0 0 0 00
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 c 1 0 1111 2222 10
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 1 0 0 0 0 c 0 0 0 0 00
1 1 0 05 06 07 0 0 0 1 07 7777 0 00 0 0 0 1 0 0 0 0 c 1 0 1111 2222 10
1 1 0 00 00 00 0 0 1 0 00 0 0 00 0 0 0 0 0 0 0 0 e 1 1 0 0 00
1 0 0 00 00 00 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 e 1 1 0 0 00
1 1 0 05 06 07 0 0 0 0 00 0 0 00 0 0 0 0 0 0 0 0 d 1 0 1111 2222 00

// ==== test/tb_issue_read_operands.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module tb_issue_read_operands;

  localparam int NCOL    = 28;
  localparam int MAX_VEC = 64;

  logic                                         clk_i;
  logic                                         rst_uarch_ni;
  logic                                         flush_i;
  logic                                         stall_i;
  issue_pkg::issue_entry_t                      issue_entry_i;
  logic                                         issue_valid_i;
  logic                                         issue_ack_o;
  logic [`ISSUE_REG_ADDR_W-1:0]                 rs1_o;
  logic [`ISSUE_REG_ADDR_W-1:0]                 rs2_o;
  logic [`ISSUE_XLEN-1:0]                       rs1_i;
  logic [`ISSUE_XLEN-1:0]                       rs2_i;
  logic                                         rs1_valid_i;
  logic                                         rs2_valid_i;
  issue_pkg::clobber_t                          clobber_i;
  issue_pkg::commit_wr_t [`ISSUE_NR_COMMIT-1:0] commit_i;
  logic                                         flu_ready_i;
  logic                                         lsu_ready_i;
  issue_pkg::fu_data_t                          fu_data_o;
  issue_pkg::fu_valid_t                         fu_valid_o;
  logic                                         stall_issue_o;

  // one row per vector, columns in data file order
  logic [`ISSUE_XLEN-1:0] vec [0:MAX_VEC-1][0:NCOL-1];
  int                     vec_count = 0;

  issue_read_operands issue_read_operands_inst (.*);

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_ack(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] t=%0t %s expected=%0b actual=%0b", $time, name, exp_v, act_v);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_addr(input string name, input logic [`ISSUE_REG_ADDR_W-1:0] exp_v,
                            input logic [`ISSUE_REG_ADDR_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, exp_v, act_v);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_data(input string name, input issue_pkg::fu_data_t exp_v,
                            input issue_pkg::fu_data_t act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_valid(input string name, input issue_pkg::fu_valid_t exp_v,
                             input issue_pkg::fu_valid_t act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, exp_v, act_v);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // vector file
  // ------------------------------
  task automatic load_vectors();
    int                     fd;
    int                     code;
    int                     col;
    int                     row;
    logic [8*128-1:0]       line;
    logic [`ISSUE_XLEN-1:0] field;
    fd = $fopen("test/issue_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open test/issue_testdata.txt");
      $display("TB FAILED");
      $fatal(1, "no vector file");
    end
    // skip the two column description lines
    code = $fgets(line, fd);
    code = $fgets(line, fd);
    col = 0;
    row = 0;
    forever begin
      code = $fscanf(fd, " %h", field);
      if (code != 1) break;
      vec[row][col] = field;
      col++;
      if (col == NCOL) begin
        col = 0;
        row++;
      end
    end
    $fclose(fd);
    if (col != 0 || row == 0) begin
      $display("vector file is empty or ends in a partial vector");
      $display("TB FAILED");
      $fatal(1, "bad vector file");
    end
    vec_count = row;
  endtask

  // entry, commit writes, scoreboard answer and controls of one vector
  task automatic drive_vector(input int n);
    issue_valid_i          = vec[n][0][0];
    issue_entry_i.fu       = issue_pkg::fu_t'(vec[n][1][3:0]);
    issue_entry_i.op       = issue_pkg::fu_op_t'(vec[n][2][6:0]);
    issue_entry_i.rs1      = vec[n][3][`ISSUE_REG_ADDR_W-1:0];
    issue_entry_i.rs2      = vec[n][4][`ISSUE_REG_ADDR_W-1:0];
    issue_entry_i.rd       = vec[n][5][`ISSUE_REG_ADDR_W-1:0];
    issue_entry_i.pc       = vec[n][6][`ISSUE_VLEN-1:0];
    issue_entry_i.result   = vec[n][7];
    issue_entry_i.trans_id = n[`ISSUE_TRANS_ID_W-1:0];
    {issue_entry_i.use_imm, issue_entry_i.use_zimm,
     issue_entry_i.use_pc, issue_entry_i.ex_valid} = vec[n][8][3:0];
    commit_i[0].we    = vec[n][9][0];
    commit_i[0].waddr = vec[n][10][`ISSUE_REG_ADDR_W-1:0];
    commit_i[0].wdata = vec[n][11];
    commit_i[1].we    = vec[n][12][0];
    commit_i[1].waddr = vec[n][13][`ISSUE_REG_ADDR_W-1:0];
    commit_i[1].wdata = vec[n][14];
    // only rs1, rs2 and rd can be clobbered
    for (int r = 0; r < 2**`ISSUE_REG_ADDR_W; r++) begin
      clobber_i[r] = issue_pkg::NONE;
    end
    clobber_i[issue_entry_i.rs1] = issue_pkg::fu_t'(vec[n][15][3:0]);
    clobber_i[issue_entry_i.rs2] = issue_pkg::fu_t'(vec[n][16][3:0]);
    clobber_i[issue_entry_i.rd]  = issue_pkg::fu_t'(vec[n][17][3:0]);
    rs1_i       = vec[n][18];
    rs1_valid_i = vec[n][19][0];
    rs2_i       = vec[n][20];
    rs2_valid_i = vec[n][21][0];
    {flu_ready_i, lsu_ready_i, stall_i, flush_i} = vec[n][22][3:0];
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main
    issue_pkg::fu_data_t  exp_data;
    issue_pkg::fu_valid_t exp_valid;
    clk_i         = 1'b0;
    rst_uarch_ni  = 1'b0;
    flush_i       = 1'b0;
    stall_i       = 1'b0;
    issue_entry_i = '0;
    issue_valid_i = 1'b0;
    rs1_i         = '0;
    rs2_i         = '0;
    rs1_valid_i   = 1'b0;
    rs2_valid_i   = 1'b0;
    commit_i      = '0;
    flu_ready_i   = 1'b1;
    lsu_ready_i   = 1'b1;
    for (int r = 0; r < 2**`ISSUE_REG_ADDR_W; r++) begin
      clobber_i[r] = issue_pkg::NONE;
    end
    load_vectors();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_uarch_ni = 1'b1;
    // id/ex register leaves reset empty since NONE and ADD encode as zero
    check_valid("fu_valid_o", '0, fu_valid_o);
    check_data("fu_data_o", '0, fu_data_o);
    for (int n = 0; n < vec_count; n++) begin
      drive_vector(n);
      // handshake and scoreboard lookup are combinational so sample mid cycle
      #10;
      check_ack("issue_ack_o", vec[n][23][0], issue_ack_o);
      check_ack("stall_issue_o", vec[n][24][0], stall_issue_o);
      check_addr("rs1_o", vec[n][3][`ISSUE_REG_ADDR_W-1:0], rs1_o);
      check_addr("rs2_o", vec[n][4][`ISSUE_REG_ADDR_W-1:0], rs2_o);
      exp_data.fu        = issue_entry_i.fu;
      exp_data.operation = issue_entry_i.op;
      exp_data.operand_a = vec[n][25];
      exp_data.operand_b = vec[n][26];
      exp_data.imm       = issue_entry_i.result;
      exp_data.trans_id  = issue_entry_i.trans_id;
      exp_valid          = issue_pkg::fu_valid_t'(vec[n][27][4:0]);
      // one cycle through the id/ex register
      @(posedge clk_i);
      @(negedge clk_i);
      check_valid("fu_valid_o", exp_valid, fu_valid_o);
      if (vec[n][23][0]) begin
        check_data("fu_data_o", exp_data, fu_data_o);
      end
    end
    $display("TB PASSED");
    $finish;
  end

  // 20 cycles per vector on top of reset
  initial begin : watchdog
    wait (vec_count > 0);
    #((vec_count * 20 + 5) * 100);
    $display("timeout, the vectors did not complete in time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
